//--- build.f
source/rv32i_types_pkg.sv
source/fetch_pipe_pkg.sv
source/fetch_stage.sv
source/branch_predictor.sv
source/fetch_hazard_unit.sv
source/instr_mem.sv
source/branch_resolver.sv
source/fetch_top.sv
verif/fetch_tb.sv

//--- source/branch_predictor.sv
/*
  Branch predictor.
  Direct mapped target buffer indexed by PC bits 4:2.
  Each entry holds a valid bit, a tag, a target and a 2-bit
  saturating counter. Lookup is combinational, updates are
  written on the clock edge.
*/
module branch_predictor import rv32i_types_pkg::*, fetch_pipe_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  word_t        current_pc,
  input  predict_upd_t upd,
  output logic         predict_taken,
  output word_t        target_addr
);

  logic [BTB_ENTRIES-1:0] vld_q;
  logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
  word_t                  tgt_q [BTB_ENTRIES];
  ctr_t                   cnt_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] rd_idx, wr_idx;
  logic [BTB_TAG_W-1:0] rd_tag, wr_tag;
  logic                 rd_hit, wr_hit;
  ctr_t                 cnt_next;

  // ########################################
  // Lookup.
  // ########################################
  assign rd_idx = current_pc[BYTE_OFF_W +: BTB_IDX_W];
  assign rd_tag = current_pc[WORD_W-1 -: BTB_TAG_W];
  assign rd_hit = vld_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  assign predict_taken = rd_hit && cnt_q[rd_idx][1];  // Upper bit means taken.
  assign target_addr   = tgt_q[rd_idx];

  // ########################################
  // Update.
  // ########################################
  assign wr_idx = upd.pc[BYTE_OFF_W +: BTB_IDX_W];
  assign wr_tag = upd.pc[WORD_W-1 -: BTB_TAG_W];
  assign wr_hit = vld_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  always_comb begin
    cnt_next = cnt_q[wr_idx];
    if (!wr_hit) begin
      // New branch. Start on the weak side of its outcome.
      cnt_next = upd.taken ? CTR_WT : CTR_WNT;
    end else if (upd.taken) begin
      case (cnt_q[wr_idx])
        CTR_SNT: cnt_next = CTR_WNT;
        CTR_WNT: cnt_next = CTR_WT;
        default: cnt_next = CTR_ST;   // Saturate.
      endcase
    end else begin
      case (cnt_q[wr_idx])
        CTR_ST:  cnt_next = CTR_WT;
        CTR_WT:  cnt_next = CTR_WNT;
        default: cnt_next = CTR_SNT;  // Saturate.
      endcase
    end
  end

  // Control state. Valid bits and counters.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        cnt_q[i] <= CTR_SNT;
      end
    end else if (upd.en) begin
      vld_q[wr_idx] <= 1'b1;
      cnt_q[wr_idx] <= cnt_next;
    end
  end

  // Tag and target storage.
  always_ff @(posedge CLK) begin
    if (upd.en) begin
      tag_q[wr_idx] <= wr_tag;
      tgt_q[wr_idx] <= upd.target;
    end
  end

endmodule

//--- source/branch_resolver.sv
/*
  Branch resolver.
  Stands in for execute. Decodes JAL and conditional branches,
  builds their immediates, resolves the outcome and drives the
  redirect and the predictor update.
*/
module branch_resolver import rv32i_types_pkg::*, fetch_pipe_pkg::*; (
  input  fetch_ex_t    entry,
  input  logic         branch_cond,  // ALU compare result.
  output redirect_t    redir,
  output predict_upd_t upd
);

  opcode_t              opcode;
  logic [IMM_J_W-1:0]   imm_j;
  logic [IMM_B_W-1:0]   imm_b;
  word_t                offset;
  word_t                target;
  logic                 is_cf;       // JAL or branch.
  logic                 taken;

  assign opcode = opcode_t'(entry.instr[OPCODE_W-1:0]);

  // ########################################
  // Immediates.
  // ########################################
  assign imm_j = {entry.instr[31], entry.instr[19:12], entry.instr[20],
                  entry.instr[30:21], 1'b0};
  assign imm_b = {entry.instr[31], entry.instr[7], entry.instr[30:25],
                  entry.instr[11:8], 1'b0};

  always_comb begin
    offset = '0;
    taken  = 1'b0;
    is_cf  = 1'b0;
    case (opcode)
      OP_JAL: begin
        offset = {{(WORD_W-IMM_J_W){imm_j[IMM_J_W-1]}}, imm_j};
        taken  = 1'b1;
        is_cf  = 1'b1;
      end
      OP_BRANCH: begin
        offset = {{(WORD_W-IMM_B_W){imm_b[IMM_B_W-1]}}, imm_b};
        taken  = branch_cond;
        is_cf  = 1'b1;
      end
      default: ;        // Falls through.
    endcase
  end

  assign target = entry.pc + offset;

  // ########################################
  // Redirect and update.
  // ########################################
  // Tags cover the whole PC, so a taken prediction always carries
  // this entry's target. Only the direction can be wrong.
  assign redir.mispredict = entry.valid && (taken != entry.prediction);
  assign redir.addr       = taken ? target : entry.pc4;

  assign upd.en     = entry.valid && is_cf;
  assign upd.pc     = entry.pc;
  assign upd.target = target;
  assign upd.taken  = taken;

endmodule

//--- source/fetch_hazard_unit.sv
/*
  Fetch hazard unit.
  Turns memory busy, the run level and execute redirects into
  PC enable, execute stall, flush and next-PC select.
*/
module fetch_hazard_unit import fetch_pipe_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      run,
  input  logic      imem_busy,
  input  redirect_t redir,
  output logic      pc_en,
  output logic      ex_stall,
  output logic      flush,
  output logic      npc_sel
);

  logic redir_q;    // Redirect seen last cycle.
  logic busy_eff;

  // A redirect onto the address already on the bus is not seen
  // as a change by the memory. Hold one cycle after every redirect.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      redir_q <= 1'b0;
    end else begin
      redir_q <= redir.mispredict;
    end
  end

  assign busy_eff = imem_busy | redir_q;

  assign pc_en    = (run & ~busy_eff) | redir.mispredict;
  assign flush    = redir.mispredict | (busy_eff & run);  // Bubble on wait.
  assign npc_sel  = redir.mispredict;
  assign ex_stall = 1'b0;   // Execute is single cycle.

endmodule

//--- source/fetch_pipe_pkg.sv
/*
  Fetch pipeline definitions.
  Reset PC, memory and predictor sizes, counter states and the
  structs passed between fetch, execute and the predictor.
*/
package fetch_pipe_pkg;
  import rv32i_types_pkg::*;

  localparam word_t RESET_PC   = 32'h200;
  localparam int IMEM_WORDS    = 64;
  localparam int IMEM_AW       = $clog2(IMEM_WORDS);
  localparam int IMEM_WAIT     = 1;                      // Busy cycles per new address.
  localparam int IMEM_WAIT_W   = $clog2(IMEM_WAIT + 1);
  localparam int BTB_ENTRIES   = 8;
  localparam int BTB_IDX_W     = $clog2(BTB_ENTRIES);   // PC bits 4:2.
  localparam int BTB_TAG_W     = WORD_W - BTB_IDX_W - BYTE_OFF_W;

  // 2-bit saturating counter.
  typedef enum logic [1:0] {CTR_SNT, CTR_WNT, CTR_WT, CTR_ST} ctr_t;

  // Fetch to execute register.
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction;   // Taken was predicted at fetch.
  } fetch_ex_t;

  // Predictor write from execute.
  typedef struct packed {
    logic  en;
    word_t pc;
    word_t target;
    logic  taken;
  } predict_upd_t;

  typedef struct packed {
    logic  mispredict;
    word_t addr;
  } redirect_t;

endpackage

//--- source/fetch_stage.sv
/*
  Fetch stage.
  PC register and next-PC mux, byte swap of the memory word,
  and the fetch to execute pipeline register.
*/
module fetch_stage import rv32i_types_pkg::*, fetch_pipe_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      pc_en,
  input  logic      flush,
  input  logic      ex_stall,
  input  logic      npc_sel,        // Take the redirect from execute.
  input  word_t     redirect_addr,
  input  logic      predict_taken,
  input  word_t     target_addr,
  input  word_t     imem_rdata,
  output word_t     current_pc,     // Also the memory address.
  output fetch_ex_t ex_entry
);

  word_t pc, pc4, npc, instr;

  // ########################################
  // PC.
  // ########################################
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4        = pc + 32'd4;
  assign current_pc = pc;

  // Redirect beats the prediction, the prediction beats pc4.
  assign npc = npc_sel       ? redirect_addr :
               predict_taken ? target_addr   : pc4;

  // Memory holds words big endian. Reverse the bytes.
  assign instr = {imem_rdata[7:0], imem_rdata[15:8],
                  imem_rdata[23:16], imem_rdata[31:24]};

  // ########################################
  // Fetch to execute register.
  // ########################################
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_entry <= '0;
    end else if (flush) begin
      ex_entry <= '0;                           // Bubble.
    end else if (!ex_stall) begin
      // Entry only counts when the PC moves past it.
      ex_entry.valid      <= pc_en;
      ex_entry.pc         <= pc;
      ex_entry.pc4        <= pc4;
      ex_entry.instr      <= instr;
      ex_entry.prediction <= predict_taken;
    end
  end

endmodule

//--- source/fetch_top.sv
/*
  Fetch top level.
  Connects the fetch stage, predictor, hazard unit,
  instruction memory and branch resolver.
*/
module fetch_top import rv32i_types_pkg::*, fetch_pipe_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      run,
  input  logic      branch_cond,
  input  logic      prog_wen,
  input  word_t     prog_addr,
  input  word_t     prog_data,
  output fetch_ex_t ex_entry
);

  // Fetch side.
  word_t current_pc, imem_rdata, target_addr;
  logic  imem_busy, predict_taken;
  // Control.
  logic  pc_en, ex_stall, flush, npc_sel;
  // Execute side.
  redirect_t    redir;
  predict_upd_t upd;

  fetch_stage fetch_i (
    .CLK(CLK), .nRST(nRST),
    .pc_en(pc_en), .flush(flush), .ex_stall(ex_stall),
    .npc_sel(npc_sel), .redirect_addr(redir.addr),
    .predict_taken(predict_taken), .target_addr(target_addr),
    .imem_rdata(imem_rdata), .current_pc(current_pc),
    .ex_entry(ex_entry)
  );

  branch_predictor predictor_i (
    .CLK(CLK), .nRST(nRST), .current_pc(current_pc), .upd(upd),
    .predict_taken(predict_taken), .target_addr(target_addr)
  );

  fetch_hazard_unit hazard_i (
    .CLK(CLK), .nRST(nRST), .run(run), .imem_busy(imem_busy),
    .redir(redir), .pc_en(pc_en), .ex_stall(ex_stall),
    .flush(flush), .npc_sel(npc_sel)
  );

  instr_mem imem_i (
    .CLK(CLK), .nRST(nRST), .addr(current_pc),
    .prog_wen(prog_wen), .prog_addr(prog_addr), .prog_data(prog_data),
    .rdata(imem_rdata), .busy(imem_busy)
  );

  // Resolves whatever sits in execute this cycle.
  branch_resolver resolver_i (
    .entry(ex_entry), .branch_cond(branch_cond),
    .redir(redir), .upd(upd)
  );

endmodule

//--- source/instr_mem.sv
/*
  Instruction memory.
  Word RAM with a load port and a fixed number of busy
  cycles after every change of the read address.
*/
module instr_mem import rv32i_types_pkg::*, fetch_pipe_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t addr,
  input  logic  prog_wen,
  input  word_t prog_addr,
  input  word_t prog_data,
  output word_t rdata,
  output logic  busy
);

  word_t                  mem [IMEM_WORDS];
  word_t                  prev_addr;
  logic [IMEM_WAIT_W-1:0] wait_cnt;
  logic                   addr_chg;

  // ########################################
  // Storage.
  // ########################################
  always_ff @(posedge CLK) begin
    if (prog_wen) begin
      mem[prog_addr[BYTE_OFF_W +: IMEM_AW]] <= prog_data;
    end
  end

  assign rdata = mem[addr[BYTE_OFF_W +: IMEM_AW]];   // Upper bits wrap.

  // ########################################
  // Wait states.
  // ########################################
  assign addr_chg = (addr != prev_addr);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prev_addr <= RESET_PC;
      wait_cnt  <= IMEM_WAIT_W'(IMEM_WAIT);    // Busy straight out of reset.
    end else if (addr_chg) begin
      prev_addr <= addr;
      wait_cnt  <= IMEM_WAIT_W'(IMEM_WAIT - 1); // This cycle is the first.
    end else if (wait_cnt != '0) begin
      wait_cnt  <= wait_cnt - 1'b1;
    end
  end

  assign busy = addr_chg || (wait_cnt != '0);

endmodule

//--- source/rv32i_types_pkg.sv
/*
  RV32I base types.
  Machine word type, major opcode enum and the widths of the
  instruction fields used when decoding jumps and branches.
*/
package rv32i_types_pkg;

  // ########################################
  // Widths.
  // ########################################
  localparam int WORD_W     = 32; // Machine word.
  localparam int BYTE_OFF_W = 2;  // Byte offset inside a word.
  localparam int OPCODE_W   = 7;  // Major opcode field.
  localparam int IMM_J_W    = 21; // J-type immediate incl. implied zero.
  localparam int IMM_B_W    = 13; // B-type immediate incl. implied zero.

  typedef logic [WORD_W-1:0] word_t;

  // ########################################
  // Major opcodes.
  // ########################################
  // Only JAL and BRANCH are acted on in this design.
  // The rest are listed so that decode reads naturally.
  typedef enum logic [OPCODE_W-1:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111, // Unconditional jump.
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011, // Conditional branch.
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

endpackage

//--- verif/fetch_tb.sv
/*
  Fetch pipeline testbench.
  Loads a program per table row through the load port, runs it and
  checks every executed entry against a model of the PC sequence.
  Covers straight-line code, a JAL loop, a forward branch both ways
  and random run-low gaps.
*/
module fetch_tb import rv32i_types_pkg::*, fetch_pipe_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_WORDS = 16;
  localparam int TIMEOUT    = 200;   // Cycles per valid entry.
  localparam int NUM_ROWS   = 6;

  // One test row.
  typedef struct packed {
    logic       loop_prog;   // Loop program, else straight line.
    logic       cond;        // Level of branch_cond for the row.
    logic       gaps;        // Random run-low cycles.
    logic [7:0] count;       // Executed entries to check.
  } row_t;

  logic      CLK, nRST, run, branch_cond, prog_wen;
  word_t     prog_addr, prog_data;
  fetch_ex_t ex_entry;
  row_t      rows [NUM_ROWS];
  int        errors, checks;
  integer    seed;
  bit        timed_out;

  fetch_top dut_i (
    .CLK(CLK), .nRST(nRST), .run(run), .branch_cond(branch_cond),
    .prog_wen(prog_wen), .prog_addr(prog_addr), .prog_data(prog_data),
    .ex_entry(ex_entry)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;   // 40 ns period.
  end

  // ########################################
  // Programs and reference model.
  // ########################################
  // Instruction at word idx from RESET_PC, in execute byte order.
  function automatic word_t prog_word(input logic loop_prog, input int idx);
    if (!loop_prog) begin
      return 32'h00008093 | (word_t'(idx) << 20);   // addi x1, x1, idx.
    end
    case (idx)
      0:       return 32'h00108093;   // addi x1, x1, 1.
      1:       return 32'h00210113;   // addi x2, x2, 2.
      2:       return 32'h00000663;   // beq x0, x0, +12 to word 5.
      3:       return 32'h00318193;   // Fall-through path.
      4:       return 32'h00420213;
      5:       return 32'h00528293;   // Branch target.
      6:       return 32'hfe9ff06f;   // jal x0, -24 back to word 0.
      default: return 32'h00000013;   // nop.
    endcase
  endfunction

  // Memory holds words big endian.
  function automatic word_t byte_swap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Next executed PC from the RV32I jump and branch rules.
  function automatic word_t model_npc(input word_t pc, input word_t instr, input logic cond);
    word_t j_off, b_off;
    j_off = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    b_off = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    if (instr[OPCODE_W-1:0] == OP_JAL) begin
      return pc + j_off;
    end
    if ((instr[OPCODE_W-1:0] == OP_BRANCH) && cond) begin
      return pc + b_off;
    end
    return pc + 32'd4;
  endfunction

  // ########################################
  // Stimulus helpers.
  // ########################################
  // One clock. Drives run, then samples at the falling edge.
  task automatic step_cycle(input logic gaps);
    @(posedge CLK);
    if (gaps) begin
      run <= (($random(seed) & 3) != 0);   // Low about one cycle in four.
    end else begin
      run <= 1'b1;
    end
    @(negedge CLK);
  endtask

  task automatic wait_entry(input logic gaps, output fetch_ex_t e, output bit ok);
    int n;
    ok = 1'b0;
    e  = '0;
    for (n = 0; (n < TIMEOUT) && !ok; n++) begin
      step_cycle(gaps);
      if (ex_entry.valid) begin
        e  = ex_entry;
        ok = 1'b1;
      end
    end
  endtask

  // Writes the program while run is low. Execute must stay empty.
  task automatic load_program(input logic loop_prog);
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge CLK);
      prog_wen  <= 1'b1;
      prog_addr <= RESET_PC + (word_t'(i) << 2);
      prog_data <= byte_swap(prog_word(loop_prog, i));
      @(negedge CLK);
      checks++;
      if (ex_entry.valid !== 1'b0) begin
        errors++;
        $display("[ERROR] %0t ex_entry.valid expected 0 got %b", $time, ex_entry.valid);
      end
    end
    @(posedge CLK);
    prog_wen <= 1'b0;
  endtask

  // ########################################
  // One table row.
  // ########################################
  task automatic run_row(input row_t row);
    word_t                 pc, exp_instr;
    fetch_ex_t             e;
    bit                    ok;
    int                    idx;
    logic [PROG_WORDS-1:0] jal_seen;   // JAL already executed once.
    @(posedge CLK);
    nRST        <= 1'b0;
    run         <= 1'b0;
    prog_wen    <= 1'b0;
    branch_cond <= row.cond;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    load_program(row.loop_prog);
    jal_seen = '0;
    pc       = RESET_PC;
    for (int k = 0; (k < row.count) && !timed_out; k++) begin
      wait_entry(row.gaps, e, ok);
      if (!ok) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: no valid entry in execute after %0d cycles", TIMEOUT);
      end else begin
        idx       = (pc - RESET_PC) >> 2;
        exp_instr = prog_word(row.loop_prog, idx);
        checks += 3;
        if (e.pc !== pc) begin
          errors++;
          $display("[ERROR] %0t ex_entry.pc expected %h got %h", $time, pc, e.pc);
        end
        if (e.pc4 !== pc + 32'd4) begin
          errors++;
          $display("[ERROR] %0t ex_entry.pc4 expected %h got %h", $time, pc + 32'd4, e.pc4);
        end
        if (e.instr !== exp_instr) begin
          errors++;
          $display("[ERROR] %0t ex_entry.instr expected %h got %h", $time, exp_instr, e.instr);
        end
        // JAL enters the buffer as weakly taken on its first pass.
        if (exp_instr[OPCODE_W-1:0] == OP_JAL) begin
          checks++;
          if (e.prediction !== jal_seen[idx]) begin
            errors++;
            $display("[ERROR] %0t ex_entry.prediction expected %b got %b",
                     $time, jal_seen[idx], e.prediction);
          end
          jal_seen[idx] = 1'b1;
        end
        pc = model_npc(pc, exp_instr, row.cond);
      end
    end
  endtask

  // ########################################
  // Main sequence.
  // ########################################
  initial begin
    nRST        = 1'b0;
    run         = 1'b0;
    branch_cond = 1'b0;
    prog_wen    = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    errors      = 0;
    checks      = 0;
    timed_out   = 1'b0;
    seed        = 32'h96ac;

    // Program, branch_cond, gaps, entries.
    rows[0] = {1'b0, 1'b0, 1'b0, 8'd14};   // Straight line.
    rows[1] = {1'b1, 1'b0, 1'b0, 8'd21};   // Loop, branch falls through.
    rows[2] = {1'b1, 1'b1, 1'b0, 8'd15};   // Loop, branch taken.
    rows[3] = {1'b1, 1'b1, 1'b1, 8'd15};
    rows[4] = {1'b1, 1'b0, 1'b1, 8'd21};
    rows[5] = {1'b0, 1'b0, 1'b1, 8'd14};

    for (int r = 0; (r < NUM_ROWS) && !timed_out; r++) begin
      run_row(rows[r]);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
